// ==== stream_buf_config.svh ====
`ifndef STREAM_BUF_CONFIG_SVH
`define STREAM_BUF_CONFIG_SVH

// ==============================
// buffer geometry
// ==============================

// byte address into the buffer memory
`define SB_AWIDTH 10

// data word width, one wishbone word
`define SB_DWIDTH 32

// ==============================
// read fifo
// ==============================

// elements held, outstanding reads included
`define SB_FIFO_DEPTH 4

`endif

// ==== stream_buf_pkg.sv ====
`include "stream_buf_config.svh"

package stream_buf_pkg;

        // byte address into the buffer
        typedef logic [`SB_AWIDTH-1:0] sb_addr_t;

        // data word or right-aligned element
        typedef logic [`SB_DWIDTH-1:0] sb_data_t;

        // element size: 0 byte, 1 half-word, 2 word, 3 invalid
        typedef logic [1:0] sb_dsize_t;

        // stream unit states
        typedef enum logic [1:0] {
                IDLE,
                BUF_TRAN,
                BUF_WAIT
        } sb_state_t;

endpackage

// ==== wb_buf_write.sv ====
`include "stream_buf_config.svh"

module wb_buf_write
        import stream_buf_pkg::*;
(
        input  logic            clk_i,
        input  logic            rstn_i,
        input  logic            wb_cyc_i,
        input  logic            wb_stb_i,
        input  logic            wb_we_i,
        input  sb_addr_t        wb_adr_i,
        input  sb_data_t        wb_dat_i,
        input  logic [3:0]      wb_sel_i,
        output logic            wb_ack_o,
        output sb_data_t        wb_dat_o,
        output logic            snoop_wr_o,
        output sb_addr_t        snoop_addr_o,
        output sb_dsize_t       snoop_dsize_o,
        output sb_data_t        mem_dat_o,
        output logic [3:0]      mem_sel_o
);

        logic           r_ack;
        sb_dsize_t      s_dsize;
        logic [1:0]     s_off;

        // single-cycle ack, one cycle after the request
        always_ff @(posedge clk_i or negedge rstn_i)
        begin
                if (!rstn_i)
                        r_ack <= 1'b0;
                else
                        r_ack <= wb_cyc_i & wb_stb_i & ~r_ack;
        end

        // select pattern gives element size and byte offset in the word
        always_comb
        begin
                case (wb_sel_i)
                4'b0001: {s_dsize, s_off} = {2'd0, 2'd0};
                4'b0010: {s_dsize, s_off} = {2'd0, 2'd1};
                4'b0100: {s_dsize, s_off} = {2'd0, 2'd2};
                4'b1000: {s_dsize, s_off} = {2'd0, 2'd3};
                4'b0011: {s_dsize, s_off} = {2'd1, 2'd0};
                4'b1100: {s_dsize, s_off} = {2'd1, 2'd2};
                4'b1111: {s_dsize, s_off} = {2'd2, 2'd0};
                default: {s_dsize, s_off} = {2'd3, 2'd0};
                endcase
        end

        assign wb_ack_o = r_ack;

        // reads are acked but carry no data
        assign wb_dat_o = '0;

        // memory write and snoop share the ack cycle of a write
        assign snoop_wr_o    = r_ack & wb_we_i;
        assign snoop_addr_o  = {wb_adr_i[`SB_AWIDTH-1:2], s_off};
        assign snoop_dsize_o = s_dsize;
        assign mem_dat_o     = wb_dat_i;
        assign mem_sel_o     = wb_sel_i;

        a_ack_in_cycle: assert property (
                @(posedge clk_i) disable iff (!rstn_i)
                wb_ack_o |-> (wb_cyc_i && wb_stb_i)
        );

endmodule

// ==== buf_mem.sv ====
`include "stream_buf_config.svh"

module buf_mem
        import stream_buf_pkg::*;
(
        input  logic            clk_i,
        input  logic            rstn_i,
        input  logic            wr_en_i,
        input  sb_addr_t        wr_addr_i,
        input  sb_data_t        wr_dat_i,
        input  logic [3:0]      wr_sel_i,
        input  logic            rd_req_i,
        output logic            rd_gnt_o,
        input  sb_addr_t        rd_addr_i,
        input  sb_dsize_t       rd_dsize_i,
        output logic            rd_valid_o,
        output sb_data_t        rd_data_o
);

        localparam int WORDS = 2 ** (`SB_AWIDTH - 2);

        sb_data_t       mem [WORDS];
        sb_data_t       r_word;
        logic [1:0]     r_off;
        sb_dsize_t      r_dsize;
        logic           r_valid;
        sb_data_t       s_shift;

        // byte-enabled write
        always_ff @(posedge clk_i)
        begin
                if (wr_en_i)
                begin
                        for (int i = 0; i < 4; i++)
                        begin
                                if (wr_sel_i[i])
                                        mem[wr_addr_i[`SB_AWIDTH-1:2]][8*i +: 8] <= wr_dat_i[8*i +: 8];
                        end
                end
        end

        // read port never stalls
        assign rd_gnt_o = rd_req_i;

        always_ff @(posedge clk_i)
        begin
                if (rd_req_i)
                begin
                        r_word  <= mem[rd_addr_i[`SB_AWIDTH-1:2]];
                        r_off   <= rd_addr_i[1:0];
                        r_dsize <= rd_dsize_i;
                end
        end

        always_ff @(posedge clk_i or negedge rstn_i)
        begin
                if (!rstn_i)
                        r_valid <= 1'b0;
                else
                        r_valid <= rd_req_i;
        end

        // ==============================
        // element extraction
        // ==============================

        always_comb
        begin
                s_shift = r_word >> {r_off, 3'b000};
                case (r_dsize)
                2'd0:    rd_data_o = sb_data_t'(s_shift[7:0]);
                2'd1:    rd_data_o = sb_data_t'(s_shift[15:0]);
                2'd2:    rd_data_o = s_shift;
                default: rd_data_o = '0;
                endcase
        end

        assign rd_valid_o = r_valid;

endmodule

// ==== tx_fifo.sv ====
`include "stream_buf_config.svh"

module tx_fifo
        import stream_buf_pkg::*;
(
        input  logic            clk_i,
        input  logic            rstn_i,
        input  logic            clr_i,
        output logic            req_o,
        input  logic            gnt_i,
        input  logic            en_i,
        input  logic            valid_i,
        input  sb_data_t        data_i,
        output sb_data_t        data_o,
        output logic            valid_o,
        input  logic            ready_i
);

        localparam int DEPTH = `SB_FIFO_DEPTH;
        localparam int PW    = $clog2(DEPTH);

        sb_data_t       r_store [DEPTH];
        logic [PW-1:0]  r_wptr;
        logic [PW-1:0]  r_rptr;
        logic [PW:0]    r_stored;
        logic [PW:0]    r_credit;
        logic [1:0]     r_clr_q;
        logic           s_take;
        logic           s_push;
        logic           s_pop;
        logic           s_drop;

        // data still in flight around a clear is thrown away
        assign s_drop = clr_i | (|r_clr_q);
        assign s_push = valid_i & ~s_drop;
        assign s_pop  = valid_o & ready_i;
        assign s_take = req_o & gnt_i;

        // credit covers stored elements and reads in flight
        assign req_o   = en_i & ~clr_i & (r_credit < DEPTH);
        assign valid_o = (r_stored != '0);
        assign data_o  = r_store[r_rptr];

        always_ff @(posedge clk_i)
        begin
                if (s_push)
                        r_store[r_wptr] <= data_i;
        end

        always_ff @(posedge clk_i or negedge rstn_i)
        begin
                if (!rstn_i)
                begin
                        r_wptr   <= '0;
                        r_rptr   <= '0;
                        r_stored <= '0;
                        r_credit <= '0;
                        r_clr_q  <= '0;
                end
                else
                begin
                        r_clr_q <= {r_clr_q[0], clr_i};
                        if (clr_i)
                        begin
                                r_wptr   <= '0;
                                r_rptr   <= '0;
                                r_stored <= '0;
                                r_credit <= '0;
                        end
                        else
                        begin
                                if (s_push)
                                        r_wptr <= (r_wptr == PW'(DEPTH-1)) ? '0 : r_wptr + 1'b1;
                                if (s_pop)
                                        r_rptr <= (r_rptr == PW'(DEPTH-1)) ? '0 : r_rptr + 1'b1;
                                r_stored <= r_stored + (PW+1)'(s_push) - (PW+1)'(s_pop);
                                r_credit <= r_credit + (PW+1)'(s_take) - (PW+1)'(s_pop);
                        end
                end
        end

        a_no_overflow: assert property (
                @(posedge clk_i) disable iff (!rstn_i)
                s_push |-> (r_stored < DEPTH)
        );

endmodule

// ==== stream_rd_unit.sv ====
`include "stream_buf_config.svh"

module stream_rd_unit
        import stream_buf_pkg::*;
(
        input  logic            clk_i,
        input  logic            rstn_i,
        input  logic            clr_i,
        input  logic            snoop_wr_i,
        input  sb_addr_t        snoop_addr_i,
        input  sb_dsize_t       snoop_dsize_i,
        output logic            rd_en_o,
        input  logic            rd_gnt_i,
        output sb_addr_t        rd_addr_o,
        output sb_dsize_t       dsize_o,
        output logic            err_o
);

        sb_state_t      r_state;
        sb_addr_t       r_wr_ptr;
        sb_addr_t       r_rd_ptr;
        sb_addr_t       r_jump_src;
        sb_addr_t       r_jump_dst;
        sb_dsize_t      r_dsize;
        logic           r_do_jump;
        logic           r_err;

        sb_addr_t       s_size_add;
        sb_addr_t       s_rd_next;
        logic           s_is_jump;
        logic           s_jmp_take;
        logic           s_at_wr;
        logic           s_last_rd;

        always_comb
        begin
                case (r_dsize)
                2'd0:    s_size_add = sb_addr_t'(1);
                2'd1:    s_size_add = sb_addr_t'(2);
                2'd2:    s_size_add = sb_addr_t'(4);
                default: s_size_add = '0;
                endcase
        end

        assign s_is_jump  = (snoop_addr_i != r_wr_ptr + s_size_add);
        assign s_jmp_take = r_do_jump && (r_rd_ptr == r_jump_src);
        assign s_rd_next  = s_jmp_take ? r_jump_dst : r_rd_ptr + s_size_add;
        assign s_at_wr    = (r_rd_ptr == r_wr_ptr);

        // the newest element is being read this cycle
        assign s_last_rd  = rd_gnt_i && s_at_wr;

        // ==============================
        // state and pointers
        // ==============================

        always_ff @(posedge clk_i or negedge rstn_i)
        begin
                if (!rstn_i || clr_i)
                begin
                        r_state    <= IDLE;
                        r_wr_ptr   <= '0;
                        r_rd_ptr   <= '0;
                        r_jump_src <= '0;
                        r_jump_dst <= '0;
                        r_dsize    <= '0;
                        r_do_jump  <= 1'b0;
                        r_err      <= 1'b0;
                end
                else
                begin
                        case (r_state)
                        IDLE:
                        begin
                                // size is fixed by the first write of the stream
                                if (snoop_wr_i)
                                begin
                                        r_wr_ptr <= snoop_addr_i;
                                        r_rd_ptr <= snoop_addr_i;
                                        r_dsize  <= snoop_dsize_i;
                                        r_state  <= BUF_TRAN;
                                end
                        end
                        BUF_TRAN:
                        begin
                                if (rd_gnt_i)
                                begin
                                        if (s_jmp_take)
                                                r_do_jump <= 1'b0;
                                        // a write landing now is the next element to read
                                        r_rd_ptr <= (s_at_wr && snoop_wr_i) ? snoop_addr_i : s_rd_next;
                                        if (s_at_wr && !snoop_wr_i)
                                                r_state <= BUF_WAIT;
                                end
                                if (snoop_wr_i)
                                begin
                                        r_wr_ptr <= snoop_addr_i;
                                        if (s_is_jump && !s_last_rd)
                                        begin
                                                if (r_do_jump && !(rd_gnt_i && s_jmp_take))
                                                        r_err <= 1'b1;
                                                else
                                                begin
                                                        r_jump_src <= r_wr_ptr;
                                                        r_jump_dst <= snoop_addr_i;
                                                        r_do_jump  <= 1'b1;
                                                end
                                        end
                                end
                        end
                        BUF_WAIT:
                        begin
                                // all data read so the next write is where to resume
                                if (snoop_wr_i)
                                begin
                                        r_wr_ptr <= snoop_addr_i;
                                        r_rd_ptr <= snoop_addr_i;
                                        r_state  <= BUF_TRAN;
                                end
                        end
                        default:
                                r_state <= IDLE;
                        endcase
                end
        end

        assign rd_en_o   = (r_state == BUF_TRAN);
        assign rd_addr_o = r_rd_ptr;
        assign dsize_o   = r_dsize;
        assign err_o     = r_err;

        // no read is granted before a stream has started
        a_idle_quiet: assert property (
                @(posedge clk_i) disable iff (!rstn_i)
                (r_state == IDLE) |-> !rd_gnt_i
        );

endmodule

// ==== stream_buf_top.sv ====
`include "stream_buf_config.svh"

module stream_buf_top
        import stream_buf_pkg::*;
(
        input  logic            clk_i,
        input  logic            rstn_i,
        input  logic            clr_i,
        input  logic            wb_cyc_i,
        input  logic            wb_stb_i,
        input  logic            wb_we_i,
        input  sb_addr_t        wb_adr_i,
        input  sb_data_t        wb_dat_i,
        input  logic [3:0]      wb_sel_i,
        output logic            wb_ack_o,
        output sb_data_t        wb_dat_o,
        output sb_data_t        out_data_o,
        output sb_dsize_t       out_dsize_o,
        output logic            out_valid_o,
        input  logic            out_ready_i,
        output logic            err_o
);

        logic           snoop_wr;
        sb_addr_t       snoop_addr;
        sb_dsize_t      snoop_dsize;
        sb_data_t       mem_dat;
        logic [3:0]     mem_sel;
        logic           rd_en;
        logic           rd_req;
        logic           rd_gnt;
        logic           rd_valid;
        sb_addr_t       rd_addr;
        sb_data_t       rd_data;

        // ==============================
        // input side
        // ==============================

        wb_buf_write u_wb (
                .clk_i         (clk_i),
                .rstn_i        (rstn_i),
                .wb_cyc_i      (wb_cyc_i),
                .wb_stb_i      (wb_stb_i),
                .wb_we_i       (wb_we_i),
                .wb_adr_i      (wb_adr_i),
                .wb_dat_i      (wb_dat_i),
                .wb_sel_i      (wb_sel_i),
                .wb_ack_o      (wb_ack_o),
                .wb_dat_o      (wb_dat_o),
                .snoop_wr_o    (snoop_wr),
                .snoop_addr_o  (snoop_addr),
                .snoop_dsize_o (snoop_dsize),
                .mem_dat_o     (mem_dat),
                .mem_sel_o     (mem_sel)
        );

        // ==============================
        // processing
        // ==============================

        buf_mem u_mem (
                .clk_i      (clk_i),
                .rstn_i     (rstn_i),
                .wr_en_i    (snoop_wr),
                .wr_addr_i  (snoop_addr),
                .wr_dat_i   (mem_dat),
                .wr_sel_i   (mem_sel),
                .rd_req_i   (rd_req),
                .rd_gnt_o   (rd_gnt),
                .rd_addr_i  (rd_addr),
                .rd_dsize_i (out_dsize_o),
                .rd_valid_o (rd_valid),
                .rd_data_o  (rd_data)
        );

        stream_rd_unit u_unit (
                .clk_i         (clk_i),
                .rstn_i        (rstn_i),
                .clr_i         (clr_i),
                .snoop_wr_i    (snoop_wr),
                .snoop_addr_i  (snoop_addr),
                .snoop_dsize_i (snoop_dsize),
                .rd_en_o       (rd_en),
                .rd_gnt_i      (rd_gnt),
                .rd_addr_o     (rd_addr),
                .dsize_o       (out_dsize_o),
                .err_o         (err_o)
        );

        // fifo output is the stream output
        tx_fifo u_fifo (
                .clk_i   (clk_i),
                .rstn_i  (rstn_i),
                .clr_i   (clr_i),
                .req_o   (rd_req),
                .gnt_i   (rd_gnt),
                .en_i    (rd_en),
                .valid_i (rd_valid),
                .data_i  (rd_data),
                .data_o  (out_data_o),
                .valid_o (out_valid_o),
                .ready_i (out_ready_i)
        );

endmodule

// ==== tb_stream_buf.sv ====
`include "stream_buf_config.svh"

module tb_stream_buf
        import stream_buf_pkg::*;
();

        localparam logic [1:0] READY_LOW    = 2'd0;
        localparam logic [1:0] READY_HIGH   = 2'd1;
        localparam logic [1:0] READY_RANDOM = 2'd2;

        logic           clk_i;
        logic           rstn_i;
        logic           clr_i;
        logic           wb_cyc_i;
        logic           wb_stb_i;
        logic           wb_we_i;
        sb_addr_t       wb_adr_i;
        sb_data_t       wb_dat_i;
        logic [3:0]     wb_sel_i;
        logic           wb_ack_o;
        sb_data_t       wb_dat_o;
        sb_data_t       out_data_o;
        sb_dsize_t      out_dsize_o;
        logic           out_valid_o;
        logic           out_ready_i;
        logic           err_o;

        // expected elements in write order with the size in the top two bits
        logic [`SB_DWIDTH+1:0]  exp_mem [256];
        int             wr_count;
        int             flush_to;
        int             rd_idx;
        int             value_errors;
        int             stray_errors;
        int             main_errors;
        int             cycles;
        logic [1:0]     ready_mode;
        logic [15:0]    data_lfsr;
        logic [15:0]    ready_lfsr;

        stream_buf_top uut (
                .clk_i       (clk_i),
                .rstn_i      (rstn_i),
                .clr_i       (clr_i),
                .wb_cyc_i    (wb_cyc_i),
                .wb_stb_i    (wb_stb_i),
                .wb_we_i     (wb_we_i),
                .wb_adr_i    (wb_adr_i),
                .wb_dat_i    (wb_dat_i),
                .wb_sel_i    (wb_sel_i),
                .wb_ack_o    (wb_ack_o),
                .wb_dat_o    (wb_dat_o),
                .out_data_o  (out_data_o),
                .out_dsize_o (out_dsize_o),
                .out_valid_o (out_valid_o),
                .out_ready_i (out_ready_i),
                .err_o       (err_o)
        );

        // ==============================
        // helpers
        // ==============================

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic sb_data_t random_word();
                sb_data_t w;
                w = '0;
                for (int i = 0; i < `SB_DWIDTH; i++)
                begin
                        w = {w[`SB_DWIDTH-2:0], data_lfsr[15]};
                        data_lfsr = lfsr_step(data_lfsr);
                end
                return w;
        endfunction

        // right-aligned and zero-filled element as it leaves the stream
        function automatic sb_data_t expected_element(input sb_data_t word, input sb_addr_t addr,
                                                      input sb_dsize_t dsize);
                sb_data_t res;
                int base;
                base = 8 * int'(addr[1:0]);
                res = '0;
                case (dsize)
                2'd0:    res[7:0] = word[base +: 8];
                2'd1:    res[15:0] = word[base +: 16];
                2'd2:    res = word;
                default: res = '0;
                endcase
                return res;
        endfunction

        function automatic logic [3:0] select_for(input sb_addr_t addr, input sb_dsize_t dsize);
                case (dsize)
                2'd0:    return 4'b0001 << addr[1:0];
                2'd1:    return 4'b0011 << addr[1:0];
                default: return 4'b1111;
                endcase
        endfunction

        function automatic int pending_count();
                if (rd_idx > flush_to)
                        return wr_count - rd_idx;
                return wr_count - flush_to;
        endfunction

        task automatic check_value(input string what, input sb_data_t got, input sb_data_t expected,
                                   inout int errors);
                if (got !== expected)
                begin
                        $display("** Error at %0t: %s is %h, expected %h",
                                 $time, what, got, expected);
                        errors = errors + 1;
                end
        endtask

        // ack is expected in the cycle after the request
        task automatic wait_ack();
                int waits;
                waits = 0;
                @(posedge clk_i);
                while (!wb_ack_o)
                begin
                        @(posedge clk_i);
                        waits = waits + 1;
                end
                check_value("wb_ack_o delay in cycles", sb_data_t'(waits), 32'd1, main_errors);
        endtask

        task automatic wb_write(input sb_addr_t addr, input sb_dsize_t dsize);
                sb_data_t data;
                data = random_word();
                exp_mem[wr_count] = {dsize, expected_element(data, addr, dsize)};
                wr_count = wr_count + 1;
                @(posedge clk_i);
                wb_cyc_i <= 1'b1;
                wb_stb_i <= 1'b1;
                wb_we_i  <= 1'b1;
                wb_adr_i <= addr;
                wb_dat_i <= data;
                wb_sel_i <= select_for(addr, dsize);
                wait_ack();
                wb_cyc_i <= 1'b0;
                wb_stb_i <= 1'b0;
                wb_we_i  <= 1'b0;
                wb_sel_i <= 4'b0000;
        endtask

        task automatic wb_read(input sb_addr_t addr);
                @(posedge clk_i);
                wb_cyc_i <= 1'b1;
                wb_stb_i <= 1'b1;
                wb_we_i  <= 1'b0;
                wb_adr_i <= addr;
                wb_sel_i <= 4'b1111;
                wait_ack();
                check_value("wb_dat_o on read", wb_dat_o, '0, main_errors);
                wb_cyc_i <= 1'b0;
                wb_stb_i <= 1'b0;
                wb_sel_i <= 4'b0000;
        endtask

        task automatic write_run(input sb_addr_t base, input int count, input sb_dsize_t dsize);
                for (int i = 0; i < count; i++)
                        wb_write(base + sb_addr_t'(i << dsize), dsize);
        endtask

        task automatic clear_stream();
                @(posedge clk_i);
                clr_i <= 1'b1;
                @(posedge clk_i);
                clr_i <= 1'b0;
                repeat (3) @(posedge clk_i);
                flush_to = wr_count;
        endtask

        task automatic wait_drained();
                while (pending_count() != 0)
                        @(posedge clk_i);
                repeat (4) @(posedge clk_i);
        endtask

        // ==============================
        // clock, ready, compare, watchdog
        // ==============================

        initial
        begin
                clk_i = 1'b0;
                forever #5 clk_i = ~clk_i;
        end

        initial
        begin
                ready_lfsr = 16'd41;
                out_ready_i <= 1'b0;
                forever
                begin
                        @(posedge clk_i);
                        case (ready_mode)
                        READY_LOW:  out_ready_i <= 1'b0;
                        READY_HIGH: out_ready_i <= 1'b1;
                        default:
                        begin
                                out_ready_i <= ready_lfsr[15];
                                ready_lfsr = lfsr_step(ready_lfsr);
                        end
                        endcase
                end
        end

        always @(posedge clk_i)
        begin
                if (rd_idx < flush_to)
                        rd_idx = flush_to;
                if (rstn_i && out_valid_o && out_ready_i)
                begin
                        if (rd_idx >= wr_count)
                        begin
                                $display("element %h left the stream with none expected", out_data_o);
                                stray_errors = stray_errors + 1;
                        end
                        else
                        begin
                                check_value("out_data_o", out_data_o,
                                            exp_mem[rd_idx][`SB_DWIDTH-1:0], value_errors);
                                check_value("out_dsize_o", sb_data_t'(out_dsize_o),
                                            sb_data_t'(exp_mem[rd_idx][`SB_DWIDTH+1:`SB_DWIDTH]),
                                            value_errors);
                                rd_idx = rd_idx + 1;
                        end
                end
        end

        initial
        begin
                cycles = 0;
                while (cycles < 40 * wr_count + 2000)
                begin
                        @(posedge clk_i);
                        cycles = cycles + 1;
                end
                $display("timeout: the run did not finish within %0d cycles", cycles);
                $display("Simulation FAILED");
                $finish;
        end

        // ==============================
        // stimulus
        // ==============================

        initial
        begin
                rstn_i     <= 1'b0;
                clr_i      <= 1'b0;
                wb_cyc_i   <= 1'b0;
                wb_stb_i   <= 1'b0;
                wb_we_i    <= 1'b0;
                wb_adr_i   <= '0;
                wb_dat_i   <= '0;
                wb_sel_i   <= 4'b0000;
                ready_mode <= READY_HIGH;
                data_lfsr = 16'd41;
                repeat (16) @(posedge clk_i);
                rstn_i <= 1'b1;
                repeat (2) @(posedge clk_i);

                // consecutive bytes
                write_run(10'h040, 16, 2'd0);
                wait_drained();
                check_value("err_o after bytes", sb_data_t'(err_o), '0, main_errors);

                // words under random back-pressure
                clear_stream();
                ready_mode <= READY_RANDOM;
                write_run(10'h100, 32, 2'd2);
                wait_drained();
                ready_mode <= READY_HIGH;

                // half-words with the reader held back so the jump stays pending
                clear_stream();
                ready_mode <= READY_LOW;
                write_run(10'h200, 8, 2'd1);
                write_run(10'h300, 8, 2'd1);
                ready_mode <= READY_HIGH;
                wait_drained();
                check_value("err_o after jump", sb_data_t'(err_o), '0, main_errors);

                // clear in the middle of a stream
                clear_stream();
                ready_mode <= READY_LOW;
                write_run(10'h080, 6, 2'd0);
                clear_stream();
                check_value("out_valid_o after clear", sb_data_t'(out_valid_o), '0, main_errors);
                ready_mode <= READY_HIGH;
                write_run(10'h380, 8, 2'd2);
                wait_drained();

                // second jump while the first is still pending
                clear_stream();
                ready_mode <= READY_LOW;
                write_run(10'h000, 6, 2'd2);
                wb_write(10'h100, 2'd2);
                wb_write(10'h200, 2'd2);
                repeat (2) @(posedge clk_i);
                check_value("err_o after double jump", sb_data_t'(err_o), 32'd1, main_errors);
                clear_stream();
                check_value("err_o after clear", sb_data_t'(err_o), '0, main_errors);

                // reads never feed the stream
                ready_mode <= READY_HIGH;
                wb_read(10'h040);
                repeat (30) @(posedge clk_i);
                check_value("out_valid_o after read", sb_data_t'(out_valid_o), '0, main_errors);

                $display("errors: %0d wrong stream values, %0d stray elements, %0d other checks",
                         value_errors, stray_errors, main_errors);
                if (value_errors + stray_errors + main_errors == 0)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

endmodule

// ==== verilog.f ====
+incdir+.
stream_buf_pkg.sv
wb_buf_write.sv
buf_mem.sv
tx_fifo.sv
stream_rd_unit.sv
stream_buf_top.sv
tb_stream_buf.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_stream_buf
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
